/* filelist.f */
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/exec_rs.sv
hdl/scalu.sv
hdl/mcalu.sv
hdl/wb_arbiter.sv
hdl/exec_core.sv
tests/exec_core_sva.sv
tests/exec_core_tb.sv

/* hdl/core_pkg.sv */
// Core package with data widths, tag types and default sizes for the execution cluster
package core_pkg;

  // Operand and result word
  typedef logic [31:0] word_t;

  // Reorder-buffer tag, also the wakeup key
  // A waiting operand keeps its producer tag in bits 7:0
  typedef logic [7:0] robid_t;

  // Destination register, bit 5 set means no destination
  typedef logic [5:0] preg_t;

  // Default station depth
  localparam int DEF_RS_ENTRIES = 32;

  // Default multi-cycle unit latency
  localparam int DEF_MC_LATENCY = 4;

endpackage

/* hdl/exec_core.sv */
// Execution cluster top with reservation station, two ALUs, two multi-cycle units and writeback
`timescale 1ns/1ns
module exec_core
  import core_pkg::*;
  import isa_pkg::*;
#(
  parameter int RS_ENTRIES = DEF_RS_ENTRIES,
  parameter int MC_LATENCY = DEF_MC_LATENCY
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    write,
  input  alu_op_e op,
  input  robid_t  robid,
  input  preg_t   rd,
  input  logic    op1ready,
  input  word_t   op1,
  input  logic    op2ready,
  input  word_t   op2,
  output logic    stall,
  output logic    wb_valid,
  output robid_t  wb_robid,
  output preg_t   wb_rd,
  output word_t   wb_result
);

  // Issue bus from the station
  alu_op_e iss_op;
  robid_t  iss_robid;
  preg_t   iss_rd;
  word_t   iss_op1, iss_op2;
  logic    sc0_issue, sc1_issue, mc0_issue, mc1_issue;
  logic    sc0_busy, sc1_busy, mc0_busy, mc1_busy;

  // Unit results toward the arbiter
  logic    sc0_done, sc1_done, mc0_done, mc1_done;
  logic    sc0_grant, sc1_grant, mc0_grant, mc1_grant;
  robid_t  sc0_robid, sc1_robid, mc0_robid, mc1_robid;
  preg_t   sc0_rd, sc1_rd, mc0_rd, mc1_rd;
  word_t   sc0_result, sc1_result, mc0_result, mc1_result;

  exec_rs #(.RS_ENTRIES(RS_ENTRIES)) u_rs (
    .clk(clk), .rst(rst), .flush(flush), .write(write),
    .op(op), .robid(robid), .rd(rd),
    .op1ready(op1ready), .op1(op1), .op2ready(op2ready), .op2(op2),
    .stall(stall),
    .iss_op(iss_op), .iss_robid(iss_robid), .iss_rd(iss_rd),
    .iss_op1(iss_op1), .iss_op2(iss_op2),
    .sc0_issue(sc0_issue), .sc1_issue(sc1_issue),
    .mc0_issue(mc0_issue), .mc1_issue(mc1_issue),
    .sc0_busy(sc0_busy), .sc1_busy(sc1_busy), .mc0_busy(mc0_busy), .mc1_busy(mc1_busy),
    .wb_valid(wb_valid), .wb_robid(wb_robid), .wb_rd(wb_rd), .wb_result(wb_result)
  );

  scalu u_scalu0 (
    .clk(clk), .rst(rst), .flush(flush), .issue(sc0_issue),
    .op(iss_op), .robid(iss_robid), .rd(iss_rd), .op1(iss_op1), .op2(iss_op2),
    .grant(sc0_grant), .busy(sc0_busy), .done(sc0_done),
    .done_robid(sc0_robid), .done_rd(sc0_rd), .done_result(sc0_result)
  );

  scalu u_scalu1 (
    .clk(clk), .rst(rst), .flush(flush), .issue(sc1_issue),
    .op(iss_op), .robid(iss_robid), .rd(iss_rd), .op1(iss_op1), .op2(iss_op2),
    .grant(sc1_grant), .busy(sc1_busy), .done(sc1_done),
    .done_robid(sc1_robid), .done_rd(sc1_rd), .done_result(sc1_result)
  );

  mcalu #(.MC_LATENCY(MC_LATENCY)) u_mcalu0 (
    .clk(clk), .rst(rst), .flush(flush), .issue(mc0_issue),
    .op(iss_op), .robid(iss_robid), .rd(iss_rd), .op1(iss_op1), .op2(iss_op2),
    .grant(mc0_grant), .busy(mc0_busy), .done(mc0_done),
    .done_robid(mc0_robid), .done_rd(mc0_rd), .done_result(mc0_result)
  );

  mcalu #(.MC_LATENCY(MC_LATENCY)) u_mcalu1 (
    .clk(clk), .rst(rst), .flush(flush), .issue(mc1_issue),
    .op(iss_op), .robid(iss_robid), .rd(iss_rd), .op1(iss_op1), .op2(iss_op2),
    .grant(mc1_grant), .busy(mc1_busy), .done(mc1_done),
    .done_robid(mc1_robid), .done_rd(mc1_rd), .done_result(mc1_result)
  );

  // Broadcast also feeds station wakeup
  wb_arbiter u_wb_arb (
    .clk(clk), .rst(rst), .flush(flush),
    .sc0_done(sc0_done), .sc0_robid(sc0_robid), .sc0_rd(sc0_rd), .sc0_result(sc0_result),
    .sc1_done(sc1_done), .sc1_robid(sc1_robid), .sc1_rd(sc1_rd), .sc1_result(sc1_result),
    .mc0_done(mc0_done), .mc0_robid(mc0_robid), .mc0_rd(mc0_rd), .mc0_result(mc0_result),
    .mc1_done(mc1_done), .mc1_robid(mc1_robid), .mc1_rd(mc1_rd), .mc1_result(mc1_result),
    .sc0_grant(sc0_grant), .sc1_grant(sc1_grant),
    .mc0_grant(mc0_grant), .mc1_grant(mc1_grant),
    .wb_valid(wb_valid), .wb_robid(wb_robid), .wb_rd(wb_rd), .wb_result(wb_result)
  );

endmodule

/* hdl/exec_rs.sv */
// Reservation station holding renamed ops until ready, then steering them to a free unit
`timescale 1ns/1ns
module exec_rs
  import core_pkg::*;
  import isa_pkg::*;
#(
  parameter int RS_ENTRIES = DEF_RS_ENTRIES
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    write,
  input  alu_op_e op,
  input  robid_t  robid,
  input  preg_t   rd,
  input  logic    op1ready,
  input  word_t   op1,
  input  logic    op2ready,
  input  word_t   op2,
  output logic    stall,
  output alu_op_e iss_op,
  output robid_t  iss_robid,
  output preg_t   iss_rd,
  output word_t   iss_op1,
  output word_t   iss_op2,
  output logic    sc0_issue,
  output logic    sc1_issue,
  output logic    mc0_issue,
  output logic    mc1_issue,
  input  logic    sc0_busy,
  input  logic    sc1_busy,
  input  logic    mc0_busy,
  input  logic    mc1_busy,
  input  logic    wb_valid,
  input  robid_t  wb_robid,
  input  preg_t   wb_rd,
  input  word_t   wb_result
);

  localparam int IW = $clog2(RS_ENTRIES);

  logic [RS_ENTRIES-1:0] ent_valid;
  logic [RS_ENTRIES-1:0] ent_rdy1;
  logic [RS_ENTRIES-1:0] ent_rdy2;
  alu_op_e               ent_op    [RS_ENTRIES];
  robid_t                ent_robid [RS_ENTRIES];
  preg_t                 ent_rd    [RS_ENTRIES];
  word_t                 ent_op1   [RS_ENTRIES];
  word_t                 ent_op2   [RS_ENTRIES];

  logic [RS_ENTRIES-1:0] ready_vec;
  logic [IW-1:0]         sel_idx;
  logic [IW-1:0]         free_idx;
  logic [IW-1:0]         ins_idx;
  logic                  sel_found;
  logic                  full;
  logic                  issued;
  logic                  accept;
  logic                  mc_class;
  logic                  wake;
  logic                  ins_match1;
  logic                  ins_match2;

  // Writebacks with no destination wake nobody
  assign wake      = wb_valid & ~wb_rd[5];
  assign ready_vec = ent_valid & ent_rdy1 & ent_rdy2;
  assign full      = &ent_valid;

  // Lowest-index ready entry is selected
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        sel_found = 1'b1;
        sel_idx   = IW'(i);
      end
    end
  end

  // Lowest free slot
  always_comb begin
    free_idx = '0;
    for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        free_idx = IW'(i);
      end
    end
  end

  assign iss_op    = ent_op[sel_idx];
  assign iss_robid = ent_robid[sel_idx];
  assign iss_rd    = ent_rd[sel_idx];
  assign iss_op1   = ent_op1[sel_idx];
  assign iss_op2   = ent_op2[sel_idx];
  assign mc_class  = is_mc_op(iss_op);

  // Steering order scalu0, scalu1, mcalu0, mcalu1; multiplies skip the scalus
  always_comb begin
    sc0_issue = 1'b0;
    sc1_issue = 1'b0;
    mc0_issue = 1'b0;
    mc1_issue = 1'b0;
    if (sel_found) begin
      if (!mc_class && !sc0_busy) begin
        sc0_issue = 1'b1;
      end else if (!mc_class && !sc1_busy) begin
        sc1_issue = 1'b1;
      end else if (!mc0_busy) begin
        mc0_issue = 1'b1;
      end else if (!mc1_busy) begin
        mc1_issue = 1'b1;
      end
    end
  end

  assign issued = sc0_issue | sc1_issue | mc0_issue | mc1_issue;

  // A full station still accepts into the slot that issues this cycle
  assign stall   = full & ~issued;
  assign accept  = write & ~stall;
  assign ins_idx = full ? sel_idx : free_idx;

  // Incoming operand may match the broadcast of this same cycle
  assign ins_match1 = wake & ~op1ready & (op1[7:0] == wb_robid);
  assign ins_match2 = wake & ~op2ready & (op2[7:0] == wb_robid);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      ent_valid <= '0;
    end else begin
      if (issued) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (accept) begin
        ent_valid[ins_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // Tag match fills waiting operands
    for (int i = 0; i < RS_ENTRIES; i++) begin
      if (wake && !ent_rdy1[i] && ent_op1[i][7:0] == wb_robid) begin
        ent_rdy1[i] <= 1'b1;
        ent_op1[i]  <= wb_result;
      end
      if (wake && !ent_rdy2[i] && ent_op2[i][7:0] == wb_robid) begin
        ent_rdy2[i] <= 1'b1;
        ent_op2[i]  <= wb_result;
      end
    end
    // Insertion overrides any wakeup into a reused slot
    if (accept) begin
      ent_op[ins_idx]    <= op;
      ent_robid[ins_idx] <= robid;
      ent_rd[ins_idx]    <= rd;
      ent_rdy1[ins_idx]  <= op1ready | ins_match1;
      ent_op1[ins_idx]   <= ins_match1 ? wb_result : op1;
      ent_rdy2[ins_idx]  <= op2ready | ins_match2;
      ent_op2[ins_idx]   <= ins_match2 ? wb_result : op2;
    end
  end

endmodule

/* hdl/isa_pkg.sv */
// ISA package with micro-op opcodes, the unit-class rule and the shared ALU datapath
package isa_pkg;

  import core_pkg::*;

  // Multi-cycle class ops have both top bits set
  typedef enum logic [4:0] {
    OP_ADD   = 5'b00000,
    OP_SUB   = 5'b00001,
    OP_AND   = 5'b00010,
    OP_OR    = 5'b00011,
    OP_XOR   = 5'b00100,
    OP_SLL   = 5'b00101,
    OP_SRL   = 5'b00110,
    OP_SRA   = 5'b00111,
    OP_SLT   = 5'b01000,
    OP_SLTU  = 5'b01001,
    OP_MUL   = 5'b11000,
    OP_MULH  = 5'b11001,
    OP_MULHU = 5'b11010
  } alu_op_e;

  function automatic logic is_mc_op(alu_op_e op);
    return &op[4:3];
  endfunction

  // ALU-class result, shifts take the low 5 bits of b
  function automatic word_t alu_calc(alu_op_e op, word_t a, word_t b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      OP_SLT:  return {31'b0, $signed(a) < $signed(b)};
      OP_SLTU: return {31'b0, a < b};
      default: return '0;
    endcase
  endfunction

endpackage

/* hdl/mcalu.sv */
// Multi-cycle unit for multiplies and ALU ops, result held until writeback grant
`timescale 1ns/1ns
module mcalu
  import core_pkg::*;
  import isa_pkg::*;
#(
  parameter int MC_LATENCY = DEF_MC_LATENCY
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    issue,
  input  alu_op_e op,
  input  robid_t  robid,
  input  preg_t   rd,
  input  word_t   op1,
  input  word_t   op2,
  input  logic    grant,
  output logic    busy,
  output logic    done,
  output robid_t  done_robid,
  output preg_t   done_rd,
  output word_t   done_result
);

  localparam int CW = $clog2(MC_LATENCY);

  logic          running;
  logic [CW-1:0] cnt;
  logic          last;
  alu_op_e       op_q;
  robid_t        robid_q;
  preg_t         rd_q;
  word_t         op1_q;
  word_t         op2_q;
  logic [63:0]   prod_s;
  logic [63:0]   prod_u;
  word_t         res;

  assign busy = running | (done & ~grant);
  assign last = running & (cnt == '0);

  // Signed and unsigned full products
  assign prod_s = $unsigned(64'($signed(op1_q)) * 64'($signed(op2_q)));
  assign prod_u = 64'(op1_q) * 64'(op2_q);

  always_comb begin
    case (op_q)
      OP_MUL:   res = prod_u[31:0];
      OP_MULH:  res = prod_s[63:32];
      OP_MULHU: res = prod_u[63:32];
      default:  res = alu_calc(op_q, op1_q, op2_q);
    endcase
  end

  // Count runs from MC_LATENCY-1 to zero, done on the following edge
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      running <= 1'b0;
      done    <= 1'b0;
    end else begin
      if (issue) begin
        running <= 1'b1;
        cnt     <= CW'(MC_LATENCY - 1);
      end else if (last) begin
        running <= 1'b0;
      end else if (running) begin
        cnt <= cnt - 1'b1;
      end
      if (last) begin
        done <= 1'b1;
      end else if (grant) begin
        done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      op_q    <= op;
      robid_q <= robid;
      rd_q    <= rd;
      op1_q   <= op1;
      op2_q   <= op2;
    end
    if (last) begin
      done_robid  <= robid_q;
      done_rd     <= rd_q;
      done_result <= res;
    end
  end

endmodule

/* hdl/scalu.sv */
// Single-cycle integer ALU with an operand stage and a result held until writeback grant
`timescale 1ns/1ns
module scalu
  import core_pkg::*;
  import isa_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  logic    issue,
  input  alu_op_e op,
  input  robid_t  robid,
  input  preg_t   rd,
  input  word_t   op1,
  input  word_t   op2,
  input  logic    grant,
  output logic    busy,
  output logic    done,
  output robid_t  done_robid,
  output preg_t   done_rd,
  output word_t   done_result
);

  logic    s1_vld;
  alu_op_e s1_op;
  robid_t  s1_robid;
  preg_t   s1_rd;
  word_t   s1_op1;
  word_t   s1_op2;

  // Free once the held result is taken
  assign busy = s1_vld | (done & ~grant);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      s1_vld <= 1'b0;
      done   <= 1'b0;
    end else begin
      s1_vld <= issue;
      if (s1_vld) begin
        done <= 1'b1;
      end else if (grant) begin
        done <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      s1_op    <= op;
      s1_robid <= robid;
      s1_rd    <= rd;
      s1_op1   <= op1;
      s1_op2   <= op2;
    end
    if (s1_vld) begin
      done_robid  <= s1_robid;
      done_rd     <= s1_rd;
      done_result <= alu_calc(s1_op, s1_op1, s1_op2);
    end
  end

endmodule

/* hdl/wb_arbiter.sv */
// Writeback arbiter granting one finished unit per cycle and registering the broadcast
`timescale 1ns/1ns
module wb_arbiter
  import core_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   flush,
  input  logic   sc0_done,
  input  robid_t sc0_robid,
  input  preg_t  sc0_rd,
  input  word_t  sc0_result,
  input  logic   sc1_done,
  input  robid_t sc1_robid,
  input  preg_t  sc1_rd,
  input  word_t  sc1_result,
  input  logic   mc0_done,
  input  robid_t mc0_robid,
  input  preg_t  mc0_rd,
  input  word_t  mc0_result,
  input  logic   mc1_done,
  input  robid_t mc1_robid,
  input  preg_t  mc1_rd,
  input  word_t  mc1_result,
  output logic   sc0_grant,
  output logic   sc1_grant,
  output logic   mc0_grant,
  output logic   mc1_grant,
  output logic   wb_valid,
  output robid_t wb_robid,
  output preg_t  wb_rd,
  output word_t  wb_result
);

  logic   any_done;
  robid_t sel_robid;
  preg_t  sel_rd;
  word_t  sel_result;

  assign any_done = sc0_done | sc1_done | mc0_done | mc1_done;

  // Fixed priority, long-latency units first
  always_comb begin
    sc0_grant  = 1'b0;
    sc1_grant  = 1'b0;
    mc0_grant  = 1'b0;
    mc1_grant  = 1'b0;
    sel_robid  = sc1_robid;
    sel_rd     = sc1_rd;
    sel_result = sc1_result;
    if (mc0_done) begin
      mc0_grant  = 1'b1;
      sel_robid  = mc0_robid;
      sel_rd     = mc0_rd;
      sel_result = mc0_result;
    end else if (mc1_done) begin
      mc1_grant  = 1'b1;
      sel_robid  = mc1_robid;
      sel_rd     = mc1_rd;
      sel_result = mc1_result;
    end else if (sc0_done) begin
      sc0_grant  = 1'b1;
      sel_robid  = sc0_robid;
      sel_rd     = sc0_rd;
      sel_result = sc0_result;
    end else if (sc1_done) begin
      sc1_grant = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= any_done;
    end
  end

  always_ff @(posedge clk) begin
    if (any_done) begin
      wb_robid  <= sel_robid;
      wb_rd     <= sel_rd;
      wb_result <= sel_result;
    end
  end

endmodule

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module exec_core_tb \
  && ./obj_dir/Vexec_core_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

/* tests/exec_core_sva.sv */
// Bound checks on reservation station issue strobes and stall behavior
`timescale 1ns/1ns
module exec_core_sva #(
  parameter int ENTRIES = 8
) (
  input logic               clk,
  input logic               rst,
  input logic               stall,
  input logic [ENTRIES-1:0] ent_valid,
  input logic               sc0_issue,
  input logic               sc1_issue,
  input logic               mc0_issue,
  input logic               mc1_issue,
  input logic               sc0_busy,
  input logic               sc1_busy,
  input logic               mc0_busy,
  input logic               mc1_busy
);

  // One op leaves the station per cycle
  a_one_strobe: assert property (@(posedge clk) disable iff (rst)
    $onehot0({sc0_issue, sc1_issue, mc0_issue, mc1_issue}))
    else $error("more than one issue strobe high in the same cycle");

  a_stall_full: assert property (@(posedge clk) disable iff (rst)
    stall |-> (&ent_valid))
    else $error("stall high while the station has a free entry");

  // Busy units never take a new op
  a_no_busy_issue: assert property (@(posedge clk) disable iff (rst)
    !((sc0_issue && sc0_busy) || (sc1_issue && sc1_busy) ||
      (mc0_issue && mc0_busy) || (mc1_issue && mc1_busy)))
    else $error("issue strobe high for a busy unit");

endmodule

bind exec_rs exec_core_sva #(.ENTRIES(RS_ENTRIES)) u_sva (
  .clk(clk), .rst(rst), .stall(stall), .ent_valid(ent_valid),
  .sc0_issue(sc0_issue), .sc1_issue(sc1_issue),
  .mc0_issue(mc0_issue), .mc1_issue(mc1_issue),
  .sc0_busy(sc0_busy), .sc1_busy(sc1_busy),
  .mc0_busy(mc0_busy), .mc1_busy(mc1_busy)
);

/* tests/exec_core_tb.sv */
// Directed testbench for the execution cluster with a robid-indexed scoreboard
`timescale 1ns/1ns
module exec_core_tb
  import core_pkg::*;
  import isa_pkg::*;
();

  localparam int RS_ENTRIES    = 8;
  localparam int MC_LATENCY    = 4;
  localparam int STALL_TIMEOUT = 200;
  localparam int WB_TIMEOUT    = 200;
  // Tag that no op ever carries
  localparam robid_t ABSENT_TAG = 8'hF0;

  logic    clk;
  logic    rst;
  logic    flush;
  logic    write;
  alu_op_e op;
  robid_t  robid;
  preg_t   rd;
  logic    op1ready;
  word_t   op1;
  logic    op2ready;
  word_t   op2;
  logic    stall;
  logic    wb_valid;
  robid_t  wb_robid;
  preg_t   wb_rd;
  word_t   wb_result;

  // Scoreboard and writeback log
  word_t   exp_val [256];
  preg_t   exp_rd [256];
  bit      exp_live [256];
  bit      got_wb [256];
  robid_t  wb_ids [$];
  preg_t   wb_rds [$];
  word_t   wb_vals [$];
  robid_t  next_id;
  logic [31:0] rng_state;
  int      value_errors;
  int      other_errors;

  alu_op_e alu_list [10] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                             OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU};
  alu_op_e mc_list [3] = '{OP_MUL, OP_MULH, OP_MULHU};

  exec_core #(.RS_ENTRIES(RS_ENTRIES), .MC_LATENCY(MC_LATENCY)) u_exec_core (
    .clk(clk), .rst(rst), .flush(flush), .write(write),
    .op(op), .robid(robid), .rd(rd),
    .op1ready(op1ready), .op1(op1), .op2ready(op2ready), .op2(op2),
    .stall(stall),
    .wb_valid(wb_valid), .wb_robid(wb_robid), .wb_rd(wb_rd), .wb_result(wb_result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Broadcast is registered, so sample it mid-cycle
  always @(negedge clk) begin
    if (!rst && wb_valid) begin
      wb_ids.push_back(wb_robid);
      wb_rds.push_back(wb_rd);
      wb_vals.push_back(wb_result);
    end
  end

  function automatic word_t next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Reference results from the opcode rules
  function automatic word_t model_result(alu_op_e o, word_t a, word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [63:0]        ps;
    logic [63:0]        pu;
    word_t              r;
    sa = $signed({{32{a[31]}}, a});
    sb = $signed({{32{b[31]}}, b});
    ps = sa * sb;
    pu = {32'h0, a} * {32'h0, b};
    case (o)
      OP_ADD:   r = a + b;
      OP_SUB:   r = a + ~b + 32'd1;
      OP_AND:   r = a & b;
      OP_OR:    r = a | b;
      OP_XOR:   r = a ^ b;
      OP_SLL:   r = a << b[4:0];
      OP_SRL:   r = a >> b[4:0];
      OP_SRA:   r = $signed(a) >>> b[4:0];
      OP_SLT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU:  r = (a < b) ? 32'd1 : 32'd0;
      OP_MUL:   r = pu[31:0];
      OP_MULH:  r = ps[63:32];
      OP_MULHU: r = pu[63:32];
      default:  r = 32'h0;
    endcase
    return r;
  endfunction

  task automatic check_result(input string name, input word_t expv, input word_t act);
    if (expv !== act) begin
      value_errors++;
      $display("Error in %s: expected result 0x%08h, actual 0x%08h", name, expv, act);
    end
  endtask

  task automatic check_robid(input string name, input robid_t expv, input robid_t act);
    if (expv !== act) begin
      value_errors++;
      $display("Error in %s: expected robid %0d, actual %0d", name, expv, act);
    end
  endtask

  task automatic check_rd(input string name, input preg_t expv, input preg_t act);
    if (expv !== act) begin
      value_errors++;
      $display("Error in %s: expected rd 0x%02h, actual 0x%02h", name, expv, act);
    end
  endtask

  // Holds write until the station accepts the op
  task automatic insert_op(input string name, input alu_op_e o, input preg_t d,
                           input logic r1, input word_t a, input logic r2, input word_t b,
                           input word_t expv, output robid_t id);
    int n;
    bit ok;
    id = next_id;
    next_id++;
    exp_val[id]  = expv;
    exp_rd[id]   = d;
    exp_live[id] = 1'b1;
    got_wb[id]   = 1'b0;
    write    = 1'b1;
    op       = o;
    robid    = id;
    rd       = d;
    op1ready = r1;
    op1      = a;
    op2ready = r2;
    op2      = b;
    n  = 0;
    ok = 1'b0;
    while (!ok && n < STALL_TIMEOUT) begin
      @(negedge clk);
      ok = !stall;
      @(posedge clk);
      #1;
      n++;
    end
    write = 1'b0;
    if (!ok) begin
      other_errors++;
      $display("%s: stall never dropped while inserting robid %0d", name, id);
    end
  endtask

  task automatic insert_batch(input string name, input int count, input bit with_mul);
    alu_op_e o;
    word_t   a;
    word_t   b;
    robid_t  id;
    for (int i = 0; i < count; i++) begin
      if (with_mul && (i % 2 == 0)) begin
        o = mc_list[(i / 2) % 3];
      end else begin
        o = alu_list[i % 10];
      end
      a = next_rand();
      b = next_rand();
      insert_op(name, o, preg_t'(i % 32), 1'b1, a, 1'b1, b, model_result(o, a, b), id);
    end
  endtask

  // Pops one writeback and matches it by robid
  task automatic collect_one(input string name, output robid_t id, output word_t v);
    int    n;
    preg_t r;
    n  = 0;
    id = '0;
    v  = '0;
    r  = '0;
    while (wb_ids.size() == 0 && n < WB_TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (wb_ids.size() == 0) begin
      other_errors++;
      $display("%s: timed out waiting for a writeback", name);
    end else begin
      id = wb_ids.pop_front();
      r  = wb_rds.pop_front();
      v  = wb_vals.pop_front();
      if (!exp_live[id]) begin
        other_errors++;
        $display("%s: robid %0d was written back but is not pending", name, id);
      end else if (got_wb[id]) begin
        other_errors++;
        $display("%s: robid %0d was written back twice", name, id);
      end else begin
        got_wb[id] = 1'b1;
        check_rd(name, exp_rd[id], r);
        check_result(name, exp_val[id], v);
      end
    end
  endtask

  task automatic collect_n(input string name, input int count);
    robid_t id;
    word_t  v;
    for (int i = 0; i < count; i++) begin
      collect_one(name, id, v);
    end
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
    if (wb_ids.size() != 0) begin
      other_errors++;
      $display("%s: %0d writebacks seen where none should occur", name, wb_ids.size());
      wb_ids.delete();
      wb_rds.delete();
      wb_vals.delete();
    end
  endtask

  task automatic wait_stall(input string name, input logic level);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < STALL_TIMEOUT) begin
      @(negedge clk);
      seen = (stall === level);
      @(posedge clk);
      #1;
      n++;
    end
    if (!seen) begin
      other_errors++;
      $display("%s: stall did not reach %0b in time", name, level);
    end
  endtask

  task automatic flush_core();
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    wb_ids.delete();
    wb_rds.delete();
    wb_vals.delete();
    for (int i = 0; i < 256; i++) begin
      exp_live[i] = 1'b0;
    end
  endtask

  task automatic test_alu_ops();
    insert_batch("alu_ops", 20, 1'b0);
    collect_n("alu_ops", 20);
    expect_quiet("alu_ops", 10);
  endtask

  task automatic test_mul_mix();
    insert_batch("mul_mix", 16, 1'b1);
    collect_n("mul_mix", 16);
    expect_quiet("mul_mix", 10);
  endtask

  task automatic test_dependency();
    word_t  a;
    word_t  b;
    word_t  c;
    word_t  pexp;
    word_t  cexp;
    word_t  v;
    robid_t pid;
    robid_t cid;
    robid_t c2id;
    robid_t qid;
    robid_t did;
    robid_t got;
    a    = next_rand();
    b    = next_rand();
    c    = next_rand();
    pexp = model_result(OP_ADD, a, b);
    cexp = model_result(OP_XOR, pexp, c);
    insert_op("dependency", OP_ADD, 6'd3, 1'b1, a, 1'b1, b, pexp, pid);
    insert_op("dependency", OP_XOR, 6'd4, 1'b0, {24'h0, pid}, 1'b1, c, cexp, cid);
    // Second link waits on the consumer through op2
    insert_op("dependency", OP_SUB, 6'd5, 1'b1, a, 1'b0, {24'h0, cid},
              model_result(OP_SUB, a, cexp), c2id);
    collect_one("dependency", got, v);
    check_robid("dependency", pid, got);
    collect_one("dependency", got, v);
    check_robid("dependency", cid, got);
    collect_one("dependency", got, v);
    check_robid("dependency", c2id, got);
    // No-destination producer wakes nobody
    insert_op("dependency", OP_OR, 6'h20, 1'b1, a, 1'b1, c, model_result(OP_OR, a, c), qid);
    insert_op("dependency", OP_ADD, 6'd7, 1'b0, {24'h0, qid}, 1'b1, b, 32'h0, did);
    exp_live[did] = 1'b0;
    collect_one("dependency", got, v);
    check_robid("dependency", qid, got);
    expect_quiet("dependency", 20);
    flush_core();
  endtask

  task automatic test_backpressure();
    robid_t id;
    for (int i = 0; i < RS_ENTRIES; i++) begin
      insert_op("backpressure", OP_ADD, 6'd1, 1'b0, {24'h0, ABSENT_TAG}, 1'b1,
                next_rand(), 32'h0, id);
      exp_live[id] = 1'b0;
    end
    wait_stall("backpressure", 1'b1);
    // One more op must be held back
    write    = 1'b1;
    op       = OP_ADD;
    robid    = next_id;
    op1ready = 1'b0;
    op1      = {24'h0, ABSENT_TAG};
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      if (!stall) begin
        other_errors++;
        $display("backpressure: stall dropped while the station was full");
      end
      @(posedge clk);
      #1;
    end
    write = 1'b0;
    flush_core();
    wait_stall("backpressure", 1'b0);
  endtask

  task automatic test_flush();
    robid_t id;
    insert_batch("flush", 6, 1'b1);
    for (int i = 0; i < 2; i++) begin
      insert_op("flush", OP_SUB, 6'd2, 1'b0, {24'h0, ABSENT_TAG}, 1'b1, next_rand(),
                32'h0, id);
    end
    flush_core();
    expect_quiet("flush", 40);
    insert_batch("flush", 8, 1'b1);
    collect_n("flush", 8);
    expect_quiet("flush", 10);
  endtask

  initial begin
    rst      = 1'b1;
    flush    = 1'b0;
    write    = 1'b0;
    op       = OP_ADD;
    robid    = '0;
    rd       = '0;
    op1ready = 1'b0;
    op1      = '0;
    op2ready = 1'b0;
    op2      = '0;
    rng_state    = 32'd56602;
    next_id      = '0;
    value_errors = 0;
    other_errors = 0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_alu_ops();
    test_mul_mix();
    test_dependency();
    test_backpressure();
    test_flush();
    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
